// File: include/csr_config.svh
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// width of every csr, the pc and tval
`define CSR_XLEN          64

`define CSR_ADDR_W        12

// MXL=2 in bits 63:62, extensions A, C, I and M
`define CSR_MISA_VAL      64'h8000_0000_0000_1105

// mstatus fields kept in machine-only mode
`define CSR_MSTATUS_MIE   3
`define CSR_MSTATUS_MPIE  7

// same bit positions in mie and mip
`define CSR_IRQ_MTI       7
`define CSR_IRQ_MEI       11

`endif

// File: hdl/csr_pkg.sv
`include "csr_config.svh"

package csr_pkg;

    typedef enum logic [1:0]
    {
        csr_op_none  = 2'd0,
        csr_op_rw    = 2'd1,
        csr_op_set   = 2'd2,
        csr_op_clear = 2'd3
    } csr_op_e;

    typedef enum logic [`CSR_ADDR_W-1:0]
    {
        csr_mstatus  = 12'h300,
        csr_misa     = 12'h301,
        csr_mie      = 12'h304,
        csr_mtvec    = 12'h305,
        csr_mscratch = 12'h340,
        csr_mepc     = 12'h341,
        csr_mcause   = 12'h342,
        csr_mtval    = 12'h343,
        csr_mip      = 12'h344,
        csr_mtimecmp = 12'hbbf,
        csr_cycle    = 12'hc00
    } csr_addr_e;

    typedef enum logic [5:0]
    {
        exc_misaligned = 6'd0,
        exc_illegal    = 6'd2,
        exc_ebreak     = 6'd3,
        irq_m_timer    = 6'd7,
        exc_ecall      = 6'd11
    } exc_code_e;

    // cause 11 is both ecall from M-mode and the machine external interrupt
    localparam exc_code_e irq_m_external = exc_ecall;

    typedef enum logic
    {
        trap_idle  = 1'b0,
        trap_entry = 1'b1
    } trap_state_e;

    typedef struct packed
    {
        logic                   valid;
        csr_op_e                op;
        logic [`CSR_ADDR_W-1:0] addr;
        logic [`CSR_XLEN-1:0]   src;
    } csr_req_t;

    typedef struct packed
    {
        logic                 valid;
        exc_code_e            code;
        logic [`CSR_XLEN-1:0] tval;
    } exc_event_t;

    typedef struct packed
    {
        logic                 valid;
        logic                 interrupt;
        exc_code_e            code;
        logic [`CSR_XLEN-1:0] epc;
        logic [`CSR_XLEN-1:0] tval;
    } trap_upd_t;

    typedef struct packed
    {
        logic                 mstatus_mie;
        logic                 mie_meie;
        logic                 mie_mtie;
        logic                 mip_meip;
        logic                 mip_mtip;
        logic [`CSR_XLEN-1:0] mtvec;
        logic [`CSR_XLEN-1:0] mepc;
        logic                 mcause_int;
        exc_code_e            mcause_code;
    } csr_status_t;

    typedef struct packed
    {
        logic                 valid;
        logic [`CSR_XLEN-1:0] pc;
    } redirect_t;

endpackage

// File: hdl/mtimer.sv
`include "csr_config.svh"

module mtimer
(
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  logic [`CSR_XLEN-1:0] i_mtimecmp,
    output logic [`CSR_XLEN-1:0] o_counter,
    output logic                 o_mtip
);

    // free-running, wraps after 2^64 cycles
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            o_counter <= '0;
        else
            o_counter <= o_counter + 1'b1;
    end

    // pending bit lags the compare by one cycle
    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            o_mtip <= 1'b0;
        else
            o_mtip <= (o_counter >= i_mtimecmp);
    end

endmodule

// File: hdl/csr_file.sv
`include "csr_config.svh"

module csr_file import csr_pkg::*;
(
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  csr_req_t             i_req,
    input  trap_upd_t            i_upd,
    input  logic                 i_mret,
    input  logic                 i_mexternal,
    input  logic [`CSR_XLEN-1:0] i_counter,
    input  logic                 i_mtip,
    output logic [`CSR_XLEN-1:0] o_rdata,
    output csr_status_t          o_status,
    output logic [`CSR_XLEN-1:0] o_mtimecmp
);

    logic                 mstatus_mie;
    logic                 mstatus_mpie;
    logic                 mie_meie;
    logic                 mie_mtie;
    logic                 mip_meip;
    logic [`CSR_XLEN-1:0] mtvec;
    logic [`CSR_XLEN-1:0] mepc;
    logic [`CSR_XLEN-1:0] mcause;
    logic [`CSR_XLEN-1:0] mtval;
    logic [`CSR_XLEN-1:0] mscratch;
    logic [`CSR_XLEN-1:0] mtimecmp;

    logic [`CSR_XLEN-1:0] mstatus_val;
    logic [`CSR_XLEN-1:0] mie_val;
    logic [`CSR_XLEN-1:0] mip_val;
    logic [`CSR_XLEN-1:0] op_result;
    logic                 wr_en;

    always_comb
    begin
        mstatus_val                    = '0;
        mstatus_val[`CSR_MSTATUS_MIE]  = mstatus_mie;
        mstatus_val[`CSR_MSTATUS_MPIE] = mstatus_mpie;
        mie_val                        = '0;
        mie_val[`CSR_IRQ_MEI]          = mie_meie;
        mie_val[`CSR_IRQ_MTI]          = mie_mtie;
        mip_val                        = '0;
        mip_val[`CSR_IRQ_MEI]          = mip_meip;
        mip_val[`CSR_IRQ_MTI]          = i_mtip;   // already registered in mtimer
    end

    always_comb
    begin
        case (i_req.addr)
            csr_mstatus:  o_rdata = mstatus_val;
            csr_misa:     o_rdata = `CSR_MISA_VAL;
            csr_mie:      o_rdata = mie_val;
            csr_mip:      o_rdata = mip_val;
            csr_mtvec:    o_rdata = mtvec;
            csr_mscratch: o_rdata = mscratch;
            csr_mepc:     o_rdata = mepc;
            csr_mcause:   o_rdata = mcause;
            csr_mtval:    o_rdata = mtval;
            csr_mtimecmp: o_rdata = mtimecmp;
            csr_cycle:    o_rdata = i_counter;
            default:      o_rdata = '0;
        endcase
    end

    // old value is whatever the read port shows this cycle
    always_comb
    begin
        case (i_req.op)
            csr_op_rw:    op_result = i_req.src;
            csr_op_set:   op_result = o_rdata | i_req.src;
            csr_op_clear: op_result = o_rdata & ~i_req.src;
            default:      op_result = o_rdata;
        endcase
    end

    // set or clear with a zero mask is only a read
    assign wr_en = i_req.valid && (i_req.op != csr_op_none)
                   && !((i_req.op != csr_op_rw) && (i_req.src == '0));

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
        begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
            mscratch     <= '0;
            mtimecmp     <= '0;
        end
        else if (i_upd.valid)
        begin
            mstatus_mpie <= mstatus_mie;
            mstatus_mie  <= 1'b0;
            mepc         <= i_upd.epc;
            mcause       <= {i_upd.interrupt, {(`CSR_XLEN-7){1'b0}}, i_upd.code};
            mtval        <= i_upd.tval;
        end
        else if (i_mret)
        begin
            mstatus_mie  <= mstatus_mpie;
            mstatus_mpie <= 1'b1;
        end
        else if (wr_en)
        begin
            case (i_req.addr)
                csr_mstatus:
                begin
                    mstatus_mie  <= op_result[`CSR_MSTATUS_MIE];
                    mstatus_mpie <= op_result[`CSR_MSTATUS_MPIE];
                end
                csr_mie:
                begin
                    mie_meie <= op_result[`CSR_IRQ_MEI];
                    mie_mtie <= op_result[`CSR_IRQ_MTI];
                end
                csr_mtvec:    mtvec    <= op_result;
                csr_mscratch: mscratch <= op_result;
                csr_mepc:     mepc     <= op_result;
                csr_mcause:   mcause   <= op_result;
                csr_mtval:    mtval    <= op_result;
                csr_mtimecmp: mtimecmp <= op_result;
                default:      ;   // misa, mip, cycle read-only
            endcase
        end
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            mip_meip <= 1'b0;
        else
            mip_meip <= i_mexternal;
    end

    assign o_status.mstatus_mie = mstatus_mie;
    assign o_status.mie_meie    = mie_meie;
    assign o_status.mie_mtie    = mie_mtie;
    assign o_status.mip_meip    = mip_meip;
    assign o_status.mip_mtip    = i_mtip;
    assign o_status.mtvec       = mtvec;
    assign o_status.mepc        = mepc;
    assign o_status.mcause_int  = mcause[`CSR_XLEN-1];
    assign o_status.mcause_code = exc_code_e'(mcause[5:0]);
    assign o_mtimecmp           = mtimecmp;

    // trap entry from trap_ctrl and mret from the core must never meet
    a_no_trap_with_mret: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        !(i_upd.valid && i_mret));

endmodule

// File: hdl/trap_ctrl.sv
`include "csr_config.svh"

module trap_ctrl import csr_pkg::*;
(
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  csr_status_t          i_status,
    input  exc_event_t           i_exc,
    input  logic [`CSR_XLEN-1:0] i_pc,
    input  logic                 i_mret,
    output trap_upd_t            o_upd,
    output redirect_t            o_redirect
);

    trap_state_e          state_q;
    trap_state_e          state_d;
    logic                 ext_take;
    logic                 tmr_take;
    logic [`CSR_XLEN-1:0] tvec_base;
    logic [`CSR_XLEN-1:0] handler_pc;

    // global enable, per-source enable and pending all needed
    assign ext_take = i_status.mstatus_mie && i_status.mie_meie && i_status.mip_meip;
    assign tmr_take = i_status.mstatus_mie && i_status.mie_mtie && i_status.mip_mtip;

    always_comb
    begin
        o_upd.valid     = (state_q == trap_idle) && (ext_take || tmr_take || i_exc.valid);
        o_upd.interrupt = 1'b0;
        o_upd.code      = i_exc.code;
        o_upd.epc       = i_pc;
        o_upd.tval      = i_exc.tval;
        if (ext_take)
        begin
            o_upd.interrupt = 1'b1;
            o_upd.code      = irq_m_external;
            o_upd.tval      = '0;
        end
        else if (tmr_take)
        begin
            o_upd.interrupt = 1'b1;
            o_upd.code      = irq_m_timer;
            o_upd.tval      = '0;
        end
    end

    always_comb
    begin
        case (state_q)
            trap_idle:  state_d = o_upd.valid ? trap_entry : trap_idle;
            trap_entry: state_d = trap_idle;   // events here are dropped
            default:    state_d = trap_idle;
        endcase
    end

    always_ff @(posedge i_csr_unit_clk or negedge i_csr_unit_rst_n)
    begin
        if (!i_csr_unit_rst_n)
            state_q <= trap_idle;
        else
            state_q <= state_d;
    end

    // mcause is already updated when we sit in entry
    assign tvec_base = {i_status.mtvec[`CSR_XLEN-1:1], 1'b0};

    always_comb
    begin
        handler_pc = tvec_base;
        if (i_status.mtvec[0] && i_status.mcause_int)
            handler_pc = tvec_base + {{(`CSR_XLEN-8){1'b0}}, i_status.mcause_code, 2'b00};
    end

    always_comb
    begin
        o_redirect.valid = 1'b0;
        o_redirect.pc    = '0;
        if (state_q == trap_entry)
        begin
            o_redirect.valid = 1'b1;
            o_redirect.pc    = handler_pc;
        end
        else if (i_mret)
        begin
            o_redirect.valid = 1'b1;
            o_redirect.pc    = i_status.mepc;
        end
    end

    // handler jump is a one-cycle pulse right after the trap edge
    a_redirect_pulse: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        o_upd.valid |=> o_redirect.valid ##1 (!o_redirect.valid || i_mret));

    // a second trap cannot be taken while the first is still in entry
    a_no_back_to_back: assert property (
        @(posedge i_csr_unit_clk) disable iff (!i_csr_unit_rst_n)
        o_upd.valid |=> !o_upd.valid);

endmodule

// File: hdl/csr_unit_top.sv
`include "csr_config.svh"

module csr_unit_top import csr_pkg::*;
(
    input  logic                 i_csr_unit_clk,
    input  logic                 i_csr_unit_rst_n,
    input  csr_req_t             i_csr_unit_req,
    input  exc_event_t           i_csr_unit_exc,
    input  logic [`CSR_XLEN-1:0] i_csr_unit_pc,
    input  logic                 i_csr_unit_mret,
    input  logic                 i_csr_unit_mexternal,
    output logic [`CSR_XLEN-1:0] o_csr_unit_rdata,
    output redirect_t            o_csr_unit_redirect
);

    csr_status_t          status;
    trap_upd_t            upd;
    logic [`CSR_XLEN-1:0] mtimecmp;
    logic [`CSR_XLEN-1:0] counter;
    logic                 mtip;

    csr_file csr_file_i
    (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_req            (i_csr_unit_req),
        .i_upd            (upd),
        .i_mret           (i_csr_unit_mret),
        .i_mexternal      (i_csr_unit_mexternal),
        .i_counter        (counter),
        .i_mtip           (mtip),
        .o_rdata          (o_csr_unit_rdata),
        .o_status         (status),
        .o_mtimecmp       (mtimecmp)
    );

    trap_ctrl trap_ctrl_i
    (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_status         (status),
        .i_exc            (i_csr_unit_exc),
        .i_pc             (i_csr_unit_pc),
        .i_mret           (i_csr_unit_mret),
        .o_upd            (upd),
        .o_redirect       (o_csr_unit_redirect)
    );

    mtimer mtimer_i
    (
        .i_csr_unit_clk   (i_csr_unit_clk),
        .i_csr_unit_rst_n (i_csr_unit_rst_n),
        .i_mtimecmp       (mtimecmp),
        .o_counter        (counter),
        .o_mtip           (mtip)
    );

endmodule

// File: verif/csr_checker.sv
`include "csr_config.svh"

module csr_checker import csr_pkg::*;
(
    input  logic                 i_clk,
    input  logic                 i_rst_n,
    input  csr_req_t             i_req,
    input  exc_event_t           i_exc,
    input  logic [`CSR_XLEN-1:0] i_pc,
    input  logic                 i_mret,
    input  logic                 i_mexternal,
    input  logic [`CSR_XLEN-1:0] i_rdata,
    input  redirect_t            i_redirect,
    input  logic                 i_test_done,
    input  int                   i_test_num,
    input  logic                 i_all_done,
    input  int                   i_tb_fails,
    output int                   o_errors
);
    timeunit 1ns;
    timeprecision 1ps;

    logic                 m_mie, m_mpie, m_meie, m_mtie, m_meip, m_mtip, m_entry;
    logic [`CSR_XLEN-1:0] m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch;
    logic [`CSR_XLEN-1:0] m_mtimecmp, m_cnt, wval, handler;
    logic                 take, ext_take, tmr_take, exp_valid;
    int                   checks = 0;
    int                   last_checks = 0;
    int                   last_errors = 0;
    int                   last_fails = 0;
    int                   n_tests = 0;

    initial o_errors = 0;

    function automatic logic [`CSR_XLEN-1:0] model_read(input logic [`CSR_ADDR_W-1:0] a);
        logic [`CSR_XLEN-1:0] r;
        r = '0;
        case (a)
            csr_mstatus:
            begin
                r[`CSR_MSTATUS_MIE]  = m_mie;
                r[`CSR_MSTATUS_MPIE] = m_mpie;
            end
            csr_misa:     r = `CSR_MISA_VAL;
            csr_mie:
            begin
                r[`CSR_IRQ_MEI] = m_meie;
                r[`CSR_IRQ_MTI] = m_mtie;
            end
            csr_mip:
            begin
                r[`CSR_IRQ_MEI] = m_meip;
                r[`CSR_IRQ_MTI] = m_mtip;
            end
            csr_mtvec:    r = m_mtvec;
            csr_mscratch: r = m_mscratch;
            csr_mepc:     r = m_mepc;
            csr_mcause:   r = m_mcause;
            csr_mtval:    r = m_mtval;
            csr_mtimecmp: r = m_mtimecmp;
            csr_cycle:    r = m_cnt;
            default:      r = '0;
        endcase
        return r;
    endfunction

    function automatic string test_name(input int n);
        case (n)
            1:       return "reset state";
            2:       return "csr operations";
            3:       return "exceptions";
            4:       return "interrupts and vectoring";
            5:       return "mret";
            default: return "timer";
        endcase
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act)
        begin
            o_errors++;
            $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    always @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            {m_mie, m_mpie, m_meie, m_mtie, m_meip, m_mtip, m_entry} <= '0;
            {m_mtvec, m_mepc, m_mcause, m_mtval, m_mscratch} <= '0;
            m_mtimecmp <= '0;
            m_cnt      <= '0;
        end
        else
        begin
            ext_take = m_mie && m_meie && m_meip;
            tmr_take = m_mie && m_mtie && m_mtip;
            take     = !m_entry && (ext_take || tmr_take || i_exc.valid);
            m_entry <= take;
            if (take)
            begin
                m_mpie <= m_mie;
                m_mie  <= 1'b0;
                m_mepc <= i_pc;
                if (ext_take || tmr_take)
                begin
                    m_mcause <= {1'b1, 57'd0, ext_take ? 6'd11 : 6'd7};
                    m_mtval  <= '0;
                end
                else
                begin
                    m_mcause <= {1'b0, 57'd0, i_exc.code};
                    m_mtval  <= i_exc.tval;
                end
            end
            else if (i_mret)
            begin
                m_mie  <= m_mpie;
                m_mpie <= 1'b1;
            end
            else if (i_req.valid && i_req.op != csr_op_none
                     && !(i_req.op != csr_op_rw && i_req.src == '0))
            begin
                wval = model_read(i_req.addr);
                case (i_req.op)
                    csr_op_set:   wval = wval | i_req.src;
                    csr_op_clear: wval = wval & ~i_req.src;
                    default:      wval = i_req.src;
                endcase
                case (i_req.addr)
                    csr_mstatus:
                    begin
                        m_mie  <= wval[`CSR_MSTATUS_MIE];
                        m_mpie <= wval[`CSR_MSTATUS_MPIE];
                    end
                    csr_mie:
                    begin
                        m_meie <= wval[`CSR_IRQ_MEI];
                        m_mtie <= wval[`CSR_IRQ_MTI];
                    end
                    csr_mtvec:    m_mtvec    <= wval;
                    csr_mscratch: m_mscratch <= wval;
                    csr_mepc:     m_mepc     <= wval;
                    csr_mcause:   m_mcause   <= wval;
                    csr_mtval:    m_mtval    <= wval;
                    csr_mtimecmp: m_mtimecmp <= wval;
                    default:      ;
                endcase
            end
            m_mtip <= (m_cnt >= m_mtimecmp);
            m_cnt  <= m_cnt + 64'd1;
            m_meip <= i_mexternal;
        end
    end

    // outputs are settled at the falling edge
    always @(negedge i_clk)
    begin
        if (i_rst_n)
        begin
            if (i_req.valid)
                check("o_csr_unit_rdata", model_read(i_req.addr), i_rdata);
            handler = {m_mtvec[63:1], 1'b0};
            if (m_mtvec[0] && m_mcause[63])
                handler = handler + {56'd0, m_mcause[5:0], 2'b00};   // 4 x cause
            exp_valid = m_entry || i_mret;
            check("o_csr_unit_redirect.valid", 64'(exp_valid), 64'(i_redirect.valid));
            if (exp_valid && i_redirect.valid)
                check("o_csr_unit_redirect.pc", m_entry ? handler : m_mepc, i_redirect.pc);
        end
    end

    always @(posedge i_test_done)
    begin
        n_tests++;
        $display("test %0d %s: %0d checks, %0d errors, %0d other failures", i_test_num,
                 test_name(i_test_num), checks - last_checks, o_errors - last_errors,
                 i_tb_fails - last_fails);
        last_checks = checks;
        last_errors = o_errors;
        last_fails  = i_tb_fails;
    end

    always @(posedge i_all_done)
        $display("%0d tests, %0d checks, %0d value errors, %0d other failures",
                 n_tests, checks, o_errors, i_tb_fails);

endmodule

// File: verif/csr_tb_top.sv
`include "csr_config.svh"

module csr_tb_top import csr_pkg::*;
    ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PLANNED_OPS = 560;
    localparam int WATCHDOG_NS = PLANNED_OPS * 20 * 10;

    logic                 clk = 1'b0;
    logic                 rst_n;
    csr_req_t             req;
    exc_event_t           exc;
    logic [`CSR_XLEN-1:0] pc;
    logic                 mret;
    logic                 mext;
    logic [`CSR_XLEN-1:0] rdata;
    redirect_t            redirect;
    logic                 test_done = 1'b0;
    logic                 all_done = 1'b0;
    int                   test_num = 0;
    int                   tb_fails = 0;
    int                   errors;
    integer               seed = 44;

    always #5 clk = ~clk;

    csr_unit_top dut_i
    (
        .i_csr_unit_clk       (clk),
        .i_csr_unit_rst_n     (rst_n),
        .i_csr_unit_req       (req),
        .i_csr_unit_exc       (exc),
        .i_csr_unit_pc        (pc),
        .i_csr_unit_mret      (mret),
        .i_csr_unit_mexternal (mext),
        .o_csr_unit_rdata     (rdata),
        .o_csr_unit_redirect  (redirect)
    );

    csr_checker chk_i
    (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_req       (req),
        .i_exc       (exc),
        .i_pc        (pc),
        .i_mret      (mret),
        .i_mexternal (mext),
        .i_rdata     (rdata),
        .i_redirect  (redirect),
        .i_test_done (test_done),
        .i_test_num  (test_num),
        .i_all_done  (all_done),
        .i_tb_fails  (tb_fails),
        .o_errors    (errors)
    );

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic csr_op(input csr_op_e op, input logic [11:0] addr, input logic [63:0] src);
        req.valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        req.src   = src;
        tick();
        req = '0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [63:0] val);
        req.valid = 1'b1;
        req.op    = csr_op_none;
        req.addr  = addr;
        req.src   = '0;
        @(negedge clk);
        val = rdata;   // read mux settled mid-cycle
        tick();
        req = '0;
    endtask

    task automatic wait_redirect(input int max_cycles, input string what);
        int n;
        n = 0;
        while (!redirect.valid && n < max_cycles)
        begin
            tick();
            n++;
        end
        if (!redirect.valid)
        begin
            $display("no redirect within %0d cycles after %s", max_cycles, what);
            tb_fails++;
        end
        tick();
    endtask

    task automatic end_test(input int n);
        test_num  = n;
        test_done = 1'b1;
        tick();
        test_done = 1'b0;
    endtask

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run did not finish in time");
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        csr_addr_e   regs[5];
        exc_code_e   codes[4];
        logic [63:0] v;
        logic [63:0] c;
        logic [63:0] prev;
        logic [63:0] cmp;
        int          since;
        logic        got;
        regs  = '{csr_mscratch, csr_mtvec, csr_mtval, csr_mepc, csr_mie};
        codes = '{exc_misaligned, exc_illegal, exc_ebreak, exc_ecall};
        rst_n = 1'b0;
        req   = '0;
        exc   = '0;
        pc    = '0;
        mret  = 1'b0;
        mext  = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        csr_read(csr_mstatus, v);
        csr_read(csr_misa, v);
        csr_read(csr_mie, v);
        csr_read(csr_mtvec, v);
        csr_read(csr_mepc, v);
        csr_read(csr_mcause, v);
        csr_read(csr_mtval, v);
        csr_read(csr_mscratch, v);
        end_test(1);

        for (int i = 0; i < 200; i++)
        begin
            v = {$random(seed), $random(seed)};
            c = {52'd0, regs[$unsigned($random(seed)) % 5]};
            csr_op(csr_op_e'(1 + $unsigned($random(seed)) % 3), c[11:0], v);
            csr_read(c[11:0], v);
        end
        end_test(2);

        csr_op(csr_op_rw, csr_mie, 64'd0);   // no interrupt may fire here
        csr_op(csr_op_rw, csr_mtimecmp, '1);
        for (int i = 0; i < 12; i++)
        begin
            csr_op(csr_op_rw, csr_mtvec, {$random(seed), $random(seed)});
            csr_op(csr_op_rw, csr_mstatus, {60'd0, 1'($random(seed)), 3'd0});
            exc.valid = 1'b1;
            exc.code  = codes[$unsigned($random(seed)) % 4];
            exc.tval  = {$random(seed), $random(seed)};
            pc        = {$random(seed), $random(seed)};
            tick();
            exc = '0;
            wait_redirect(5, "an exception");
            csr_read(csr_mepc, v);
            csr_read(csr_mcause, v);
            csr_read(csr_mtval, v);
            csr_read(csr_mstatus, v);
        end
        end_test(3);

        csr_op(csr_op_rw, csr_mtvec, {$random(seed), $random(seed) & 32'hffff_fffc | 32'd1});
        csr_op(csr_op_rw, csr_mie, 64'h800);
        mext = 1'b1;
        repeat (5)
        begin
            tick();
            if (redirect.valid)
            begin
                $display("masked external interrupt caused a redirect");
                tb_fails++;
            end
        end
        csr_op(csr_op_set, csr_mstatus, 64'h8);
        wait_redirect(3, "an enabled external interrupt");
        csr_read(csr_mcause, v);
        mext = 1'b0;
        csr_op(csr_op_rw, csr_mtimecmp, 64'd0);
        csr_op(csr_op_rw, csr_mie, 64'h880);
        mext = 1'b1;
        tick();
        tick();
        csr_op(csr_op_set, csr_mstatus, 64'h8);   // external and timer both pending
        wait_redirect(3, "two pending interrupts");
        csr_read(csr_mcause, v);
        csr_op(csr_op_rw, csr_mie, 64'd0);
        mext = 1'b0;
        csr_op(csr_op_rw, csr_mtimecmp, '1);
        end_test(4);

        for (int i = 0; i < 6; i++)
        begin
            csr_op(csr_op_rw, csr_mepc, {$random(seed), $random(seed)});
            csr_op(csr_op_rw, csr_mstatus, {56'd0, 8'($random(seed))} & 64'h88);
            mret = 1'b1;
            @(negedge clk);
            if (!redirect.valid)
            begin
                $display("mret gave no redirect in the same cycle");
                tb_fails++;
            end
            tick();
            mret = 1'b0;
            csr_read(csr_mstatus, v);
        end
        csr_op(csr_op_rw, csr_mstatus, 64'd0);
        end_test(5);

        csr_read(csr_cycle, c);
        cmp = c + 64'd8;
        csr_op(csr_op_rw, csr_mtimecmp, cmp);
        prev  = c;
        since = -1;
        got   = 1'b0;
        for (int i = 0; i < 30 && !got; i++)
        begin
            csr_read(csr_cycle, c);
            if (c < prev)
            begin
                $display("cycle counter went backwards");
                tb_fails++;
            end
            prev = c;
            if (c > cmp && since < 0)
                since = 0;
            csr_read(csr_mip, v);
            if (v[`CSR_IRQ_MTI])
                got = 1'b1;
            else if (since >= 0)
                since += 2;
        end
        if (!got || since > 10)
        begin
            $display("timer pending bit did not rise in time");
            tb_fails++;
        end
        csr_op(csr_op_rw, csr_mtimecmp, '1);
        tick();
        tick();
        csr_read(csr_mip, v);
        end_test(6);

        all_done = 1'b1;
        tick();
        if (errors == 0 && tb_fails == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// File: files.f
+incdir+include
hdl/csr_pkg.sv
hdl/mtimer.sv
hdl/csr_file.sv
hdl/trap_ctrl.sv
hdl/csr_unit_top.sv
verif/csr_checker.sv
verif/csr_tb_top.sv

// File: run.sh
#!/bin/bash
# build and run the CSR unit regression with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module csr_tb_top -o csr_sim \
    && ./obj_dir/csr_sim | tee /dev/stderr | grep -q "Regression passed" \
    && echo "simulation ok" \
    || { echo "simulation failed"; exit 1; }
